// ==== vlog.f ====
hdl/tcb_pkg.sv
hdl/tcb_misaligned.sv
hdl/tcb_memory.sv
hdl/tcb_cfg_regs.sv
hdl/tcb_subsystem.sv
test/tcb_subsystem_tb.sv

// ==== run_verilator.sh ====
#!/bin/sh
# Compile and run the testbench with Verilator; exit status 0 only on a pass.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f vlog.f \
  --top-module tcb_subsystem_tb -o tcb_sim
if [ $? -ne 0 ]; then
  echo "compile failed"
  exit 1
fi

./obj_dir/tcb_sim > sim.log 2>&1
run_status=$?
cat sim.log
if [ $run_status -ne 0 ]; then
  echo "simulation exited with status $run_status"
  exit 1
fi

if grep -qx "Test passed" sim.log; then
  exit 0
fi
echo "pass message not found in sim.log"
exit 1

// ==== test/tcb_subsystem_tb.sv ====
// directed testbench for the tcb memory subsystem, run as top module against the DUT tcb_subsystem
`default_nettype none

module tcb_subsystem_tb
  import tcb_pkg::*;
();

  localparam int unsigned timeout_cycles = 20;
  localparam int unsigned rnd_count      = 200;

  logic     clk;
  logic     rst_n;
  logic     vld;
  tcb_req_t req;
  logic     rsp_vld;
  tcb_rsp_t rsp;
  wb_req_t  wb_req;
  wb_rsp_t  wb_rsp;

  // byte array model of the memory plus the register state
  logic [tcb_unt-1:0] model_mem [0:(1<<tcb_adr)-1];
  logic               model_cross;
  int unsigned        model_err_cnt;
  string              test_name;
  int                 seed;

  tcb_subsystem i_tcb_subsystem (
    .clk     (clk),
    .rst_n   (rst_n),
    .vld     (vld),
    .req     (req),
    .rsp_vld (rsp_vld),
    .rsp     (rsp),
    .wb_req  (wb_req),
    .wb_rsp  (wb_rsp)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  //////////////////////////////////////////////////////////////////////
  // reporting
  //////////////////////////////////////////////////////////////////////

  task automatic stop_on_error();
    $display("Test failed");
    $fatal(1, "simulation stopped at first error");
  endtask

  task automatic check(input string what, input logic [tcb_dat-1:0] exp,
                       input logic [tcb_dat-1:0] act);
    if (act !== exp) begin
      $display("CHECK FAILED %s %s: expected %h, actual %h", test_name, what, exp, act);
      stop_on_error();
    end
  endtask

  task automatic report_timeout(input string what);
    $display("timeout in %s, no %s within %0d cycles", test_name, what, timeout_cycles);
    stop_on_error();
  endtask

  //////////////////////////////////////////////////////////////////////
  // reference model and bus helpers
  //////////////////////////////////////////////////////////////////////

  // applies one access to the model, returns expected rdt and sts
  task automatic model_access(input logic wen, input tcb_ndn_t ndn, input tcb_siz_t siz,
                              input logic [tcb_adr-1:0] adr, input logic [tcb_dat-1:0] wdt,
                              output logic [tcb_dat-1:0] exp_rdt, output logic exp_sts);
    int unsigned n;
    int unsigned off;
    int unsigned base;
    int unsigned lane;
    int unsigned k;
    n = 1 << siz;
    off = adr % tcb_ben;
    base = adr - off;
    exp_rdt = '0;
    exp_sts = 1'b0;
    if ((off + n > tcb_ben) && !model_cross) begin
      // rejected, nothing written, counter saturates
      exp_sts = 1'b1;
      if (model_err_cnt < 255) model_err_cnt++;
    end else begin
      for (k = 0; k < n; k++) begin
        if (ndn == tcb_little) lane = (off + k) % tcb_ben;
        else lane = (off + n - 1 - k) % tcb_ben;
        if (wen) model_mem[base + lane] = wdt[tcb_unt*k +: tcb_unt];
        else exp_rdt[tcb_unt*k +: tcb_unt] = model_mem[base + lane];
      end
    end
  endtask

  // single tcb access, response checked when rsp_vld shows up
  task automatic tcb_access(input logic wen, input tcb_ndn_t ndn, input tcb_siz_t siz,
                            input logic [tcb_adr-1:0] adr, input logic [tcb_dat-1:0] wdt);
    logic [tcb_dat-1:0] exp_rdt;
    logic               exp_sts;
    int unsigned        cnt;
    @(negedge clk);
    vld = 1'b1;
    req.wen = wen;
    req.ndn = ndn;
    req.siz = siz;
    req.adr = adr;
    req.wdt = wdt;
    model_access(wen, ndn, siz, adr, wdt, exp_rdt, exp_sts);
    @(negedge clk);
    vld = 1'b0;
    cnt = 0;
    while (!rsp_vld) begin
      if (cnt == timeout_cycles) report_timeout("tcb response");
      @(negedge clk);
      cnt++;
    end
    check("sts", tcb_dat'(exp_sts), tcb_dat'(rsp.sts));
    // write responses carry old memory data, only reads and rejects are checked
    if (!wen || exp_sts) check("rdt", exp_rdt, rsp.rdt);
  endtask

  task automatic wb_cycle(input logic we, input logic [wb_adr-1:0] adr,
                          input logic [tcb_dat-1:0] dat, output logic [tcb_dat-1:0] rdat);
    int unsigned cnt;
    @(negedge clk);
    wb_req.cyc = 1'b1;
    wb_req.stb = 1'b1;
    wb_req.we = we;
    wb_req.adr = adr;
    wb_req.dat_w = dat;
    cnt = 0;
    @(negedge clk);
    while (!wb_rsp.ack) begin
      if (cnt == timeout_cycles) report_timeout("wishbone ack");
      @(negedge clk);
      cnt++;
    end
    rdat = wb_rsp.dat_r;
    // ack seen, end the cycle
    wb_req.cyc = 1'b0;
    wb_req.stb = 1'b0;
    wb_req.we = 1'b0;
  endtask

  task automatic wb_write(input logic [wb_adr-1:0] adr, input logic [tcb_dat-1:0] dat);
    logic [tcb_dat-1:0] unused;
    wb_cycle(1'b1, adr, dat, unused);
  endtask

  task automatic wb_read(input logic [wb_adr-1:0] adr, output logic [tcb_dat-1:0] rdat);
    wb_cycle(1'b0, adr, '0, rdat);
  endtask

  //////////////////////////////////////////////////////////////////////
  // tests
  //////////////////////////////////////////////////////////////////////

  task automatic aligned_words_test();
    test_name = "aligned_words";
    tcb_access(1'b1, tcb_little, tcb_siz_word, 10'd0, 32'h1122_3344);
    tcb_access(1'b1, tcb_big, tcb_siz_word, 10'd4, 32'ha1b2_c3d4);
    tcb_access(1'b0, tcb_little, tcb_siz_word, 10'd0, '0);
    tcb_access(1'b0, tcb_big, tcb_siz_word, 10'd0, '0);
    tcb_access(1'b0, tcb_little, tcb_siz_word, 10'd4, '0);
    tcb_access(1'b0, tcb_big, tcb_siz_word, 10'd4, '0);
  endtask

  // every non-crossing byte and halfword offset, upper wdt bits are junk
  task automatic subword_test();
    int unsigned e;
    int unsigned s;
    int unsigned off;
    test_name = "subword";
    tcb_access(1'b1, tcb_little, tcb_siz_word, 10'd16, '0);
    for (e = 0; e < 2; e++) begin
      for (s = 0; s < 2; s++) begin
        for (off = 0; off + (1 << s) <= tcb_ben; off++) begin
          tcb_access(1'b1, tcb_ndn_t'(e), tcb_siz_t'(s), tcb_adr'(16 + off),
                     32'hc0de_0000 | (32'h1357 + e*64 + s*16 + off));
          tcb_access(1'b0, tcb_little, tcb_siz_word, 10'd16, '0);
          tcb_access(1'b0, tcb_ndn_t'(e), tcb_siz_t'(s), tcb_adr'(16 + off), '0);
        end
      end
    end
  endtask

  task automatic cross_reject_test();
    int unsigned e;
    int unsigned s;
    int unsigned off;
    int unsigned w;
    logic [tcb_dat-1:0] rdat;
    test_name = "cross_reject";
    tcb_access(1'b1, tcb_little, tcb_siz_word, 10'd32, 32'h0123_4567);
    for (e = 0; e < 2; e++) begin
      for (w = 0; w < 2; w++) begin
        for (s = 1; s < 3; s++) begin
          for (off = 1; off < tcb_ben; off++) begin
            if (off + (1 << s) > tcb_ben) begin
              tcb_access(w[0], tcb_ndn_t'(e), tcb_siz_t'(s), tcb_adr'(32 + off), 32'hffee_ddcc);
            end
          end
        end
      end
    end
    tcb_access(1'b0, tcb_little, tcb_siz_word, 10'd32, '0);
    wb_read(reg_err_cnt, rdat);
    check("err_cnt", tcb_dat'(model_err_cnt), rdat);
  endtask

  task automatic cross_wrap_test();
    int unsigned e;
    int unsigned s;
    int unsigned off;
    test_name = "cross_wrap";
    wb_write(reg_ctrl, 32'd1);
    model_cross = 1'b1;
    tcb_access(1'b1, tcb_little, tcb_siz_word, 10'd48, '0);
    for (e = 0; e < 2; e++) begin
      for (s = 1; s < 3; s++) begin
        for (off = 1; off < tcb_ben; off++) begin
          if (off + (1 << s) > tcb_ben) begin
            tcb_access(1'b1, tcb_ndn_t'(e), tcb_siz_t'(s), tcb_adr'(48 + off),
                       32'h8899_aabb + e*256 + s*16 + off);
            tcb_access(1'b0, tcb_little, tcb_siz_word, 10'd48, '0);
            tcb_access(1'b0, tcb_ndn_t'(e), tcb_siz_t'(s), tcb_adr'(48 + off), '0);
          end
        end
      end
    end
  endtask

  task automatic register_test();
    logic [tcb_dat-1:0] rdat;
    test_name = "registers";
    wb_read(reg_ctrl, rdat);
    check("ctrl", 32'd1, rdat);
    wb_write(reg_ctrl, 32'd0);
    model_cross = 1'b0;
    wb_read(reg_ctrl, rdat);
    check("ctrl", 32'd0, rdat);
    wb_read(reg_err_cnt, rdat);
    check("err_cnt", tcb_dat'(model_err_cnt), rdat);
    // any written value clears the counter
    wb_write(reg_err_cnt, 32'hffff_ffff);
    model_err_cnt = 0;
    wb_read(reg_err_cnt, rdat);
    check("err_cnt", 32'd0, rdat);
    wb_read(2'd2, rdat);
    check("unmapped 2", 32'd0, rdat);
    wb_read(2'd3, rdat);
    check("unmapped 3", 32'd0, rdat);
  endtask

  // one request per cycle, response of the previous one checked alongside
  task automatic random_test();
    int unsigned        i;
    int                 r;
    logic               pend;
    logic               pend_wen;
    logic [tcb_dat-1:0] pend_rdt;
    logic               pend_sts;
    logic [tcb_dat-1:0] rdat;
    test_name = "random";
    for (i = 0; i < 16; i++) begin
      tcb_access(1'b1, tcb_little, tcb_siz_word, tcb_adr'(i*4), $random(seed));
    end
    pend = 1'b0;
    for (i = 0; i <= rnd_count; i++) begin
      @(negedge clk);
      if (pend) begin
        check("rsp_vld", 32'd1, tcb_dat'(rsp_vld));
        check("sts", tcb_dat'(pend_sts), tcb_dat'(rsp.sts));
        if (!pend_wen || pend_sts) check("rdt", pend_rdt, rsp.rdt);
      end
      if (i == rnd_count) begin
        vld = 1'b0;
      end else begin
        r = $random(seed);
        vld = 1'b1;
        req.wen = r[0];
        req.ndn = tcb_ndn_t'(r[1]);
        req.siz = tcb_siz_t'(r[7:4] % 3);
        req.adr = tcb_adr'(r[13:8]);
        req.wdt = $random(seed);
        model_access(req.wen, req.ndn, req.siz, req.adr, req.wdt, pend_rdt, pend_sts);
        pend_wen = req.wen;
        pend = 1'b1;
      end
    end
    wb_read(reg_err_cnt, rdat);
    check("err_cnt", tcb_dat'(model_err_cnt), rdat);
  endtask

  //////////////////////////////////////////////////////////////////////
  // main sequence
  //////////////////////////////////////////////////////////////////////

  initial begin
    rst_n = 1'b0;
    vld = 1'b0;
    req = '0;
    wb_req = '0;
    model_cross = 1'b0;
    model_err_cnt = 0;
    seed = 80130;
    test_name = "reset";
    repeat (5) @(negedge clk);
    rst_n = 1'b1;
    aligned_words_test();
    subword_test();
    cross_reject_test();
    cross_wrap_test();
    register_test();
    random_test();
    $display("Test passed");
    $finish;
  end

endmodule

`default_nettype wire

// ==== hdl/tcb_subsystem.sv ====
// top level of the misaligned tcb memory subsystem, the testbench connects its DUT here
`default_nettype none

module tcb_subsystem
  import tcb_pkg::*;
(
  input  logic     clk,
  input  logic     rst_n,
  // tcb port from the cpu side manager
  input  logic     vld,
  input  tcb_req_t req,
  output logic     rsp_vld,
  output tcb_rsp_t rsp,
  // wishbone configuration port
  input  wb_req_t  wb_req,
  output wb_rsp_t  wb_rsp
);

  //////////////////////////////////////////////////////////////////////
  // internal wiring
  //////////////////////////////////////////////////////////////////////

  logic               allow_cross;
  logic               err_evt;
  logic               mem_vld;
  mem_req_t           mem_req;
  logic [tcb_dat-1:0] mem_rdt;

  // request conversion and read realignment
  tcb_misaligned i_tcb_misaligned (
    .clk         (clk),
    .rst_n       (rst_n),
    .vld         (vld),
    .req         (req),
    .rsp_vld     (rsp_vld),
    .rsp         (rsp),
    .allow_cross (allow_cross),
    .err_evt     (err_evt),
    .mem_vld     (mem_vld),
    .mem_req     (mem_req),
    .mem_rdt     (mem_rdt)
  );

  // word storage
  tcb_memory i_tcb_memory (
    .clk     (clk),
    .mem_vld (mem_vld),
    .mem_req (mem_req),
    .mem_rdt (mem_rdt)
  );

  // control bit and error counter
  tcb_cfg_regs i_tcb_cfg_regs (
    .clk         (clk),
    .rst_n       (rst_n),
    .wb_req      (wb_req),
    .wb_rsp      (wb_rsp),
    .allow_cross (allow_cross),
    .err_evt     (err_evt)
  );

endmodule

`default_nettype wire

// ==== hdl/tcb_cfg_regs.sv ====
// wishbone classic register block steering cross-boundary handling and counting rejected accesses
`default_nettype none

module tcb_cfg_regs
  import tcb_pkg::*;
(
  input  logic     clk,
  input  logic     rst_n,
  // wishbone classic subordinate port
  input  wb_req_t  wb_req,
  output wb_rsp_t  wb_rsp,
  // converter control and status
  output logic     allow_cross,
  input  logic     err_evt
);

  //////////////////////////////////////////////////////////////////////
  // bus handshake
  //////////////////////////////////////////////////////////////////////

  logic               ack;
  logic               acc;  // access accepted in this cycle
  logic               wr;
  logic [7:0]         err_cnt;
  logic [tcb_dat-1:0] dat_r;

  // single cycle ack, low again before the manager drops stb
  assign acc = wb_req.cyc & wb_req.stb & ~ack;
  assign wr  = acc & wb_req.we;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      ack <= 1'b0;
    end else begin
      ack <= acc;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // registers
  //////////////////////////////////////////////////////////////////////

  // control, bit 0 lets crossing accesses wrap inside the word
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      allow_cross <= 1'b0;
    end else if (wr && (wb_req.adr == reg_ctrl)) begin
      allow_cross <= wb_req.dat_w[0];
    end
  end

  // rejected access counter, saturating
  // a clear write takes priority over a new event
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      err_cnt <= '0;
    end else if (wr && (wb_req.adr == reg_err_cnt)) begin
      err_cnt <= '0;
    end else if (err_evt && !(&err_cnt)) begin
      err_cnt <= err_cnt + 8'd1;
    end
  end

  // read data captured together with the ack
  always_ff @(posedge clk) begin
    if (acc) begin
      case (wb_req.adr)
        reg_ctrl:    dat_r <= tcb_dat'(allow_cross);
        reg_err_cnt: dat_r <= tcb_dat'(err_cnt);
        default:     dat_r <= '0;  // unmapped
      endcase
    end
  end

  assign wb_rsp.ack   = ack;
  assign wb_rsp.dat_r = dat_r;

  // every access gets exactly one ack cycle
  a_ack_single: assert property (@(posedge clk) disable iff (!rst_n)
    ack |=> !ack);

endmodule

`default_nettype wire

// ==== hdl/tcb_memory.sv ====
// single cycle word memory with byte lane writes, placed behind the misaligned converter
`default_nettype none

module tcb_memory
  import tcb_pkg::*;
(
  input  logic               clk,
  // aligned access from the converter
  input  logic               mem_vld,
  input  mem_req_t           mem_req,
  output logic [tcb_dat-1:0] mem_rdt
);

  //////////////////////////////////////////////////////////////////////
  // storage
  //////////////////////////////////////////////////////////////////////

  localparam int unsigned mem_depth = 2**(tcb_adr-tcb_off);

  // one entry per word, split into byte lanes
  logic [tcb_ben-1:0][tcb_unt-1:0] mem [0:mem_depth-1];

  // write data viewed per lane
  logic [tcb_ben-1:0][tcb_unt-1:0] wdt_lan;

  assign wdt_lan = mem_req.wdt;

  //////////////////////////////////////////////////////////////////////
  // access
  //////////////////////////////////////////////////////////////////////

  // read is registered on every access
  // a write returns the word as it was before the write
  always_ff @(posedge clk) begin
    if (mem_vld) begin
      mem_rdt <= mem[mem_req.adr];
    end
  end

  // per lane write, lanes without enable keep their byte
  always_ff @(posedge clk) begin
    if (mem_vld && mem_req.wen) begin
      for (int unsigned i = 0; i < tcb_ben; i++) begin
        if (mem_req.ben[i]) begin
          mem[mem_req.adr][i] <= wdt_lan[i];
        end
      end
    end
  end

  // converter gates byte enables outside valid cycles
  a_ben_idle: assert property (@(posedge clk)
    (mem_req.wen && (|mem_req.ben)) |-> mem_vld);

endmodule

`default_nettype wire

// ==== hdl/tcb_misaligned.sv ====
// converter from sub-word and misaligned tcb requests to aligned byte-enabled word accesses
`default_nettype none

module tcb_misaligned
  import tcb_pkg::*;
(
  input  logic               clk,
  input  logic               rst_n,
  // tcb subordinate side
  input  logic               vld,
  input  tcb_req_t           req,
  output logic               rsp_vld,
  output tcb_rsp_t           rsp,
  // configuration block
  input  logic               allow_cross,
  output logic               err_evt,
  // aligned memory side
  output logic               mem_vld,
  output mem_req_t           mem_req,
  input  logic [tcb_dat-1:0] mem_rdt
);

  // lane that request byte k maps onto
  // big endian mirrors the bytes inside the n byte window
  function automatic logic [tcb_off-1:0] lane_of(
    input tcb_ndn_t           ndn,
    input logic [tcb_off-1:0] off,
    input logic [tcb_off:0]   num,
    input logic [tcb_off-1:0] k
  );
    logic [tcb_off-1:0] lane;
    if (ndn == tcb_big) begin
      lane = off + num[tcb_off-1:0] - tcb_off'(1) - k;
    end else begin
      lane = off + k;
    end
    return lane;
  endfunction

  //////////////////////////////////////////////////////////////////////
  // request stage
  //////////////////////////////////////////////////////////////////////

  logic [tcb_off-1:0]                    req_off;
  logic [tcb_off:0]                      req_num;  // 1, 2 or 4 bytes
  logic [tcb_ben-1:0]                    req_msk;
  logic                                  req_crs;
  logic                                  req_rej;
  logic [tcb_ben-1:0][tcb_unt-1:0]       req_wdt;
  logic [tcb_ben-1:0][tcb_unt-1:0]       lan_wdt;
  logic [tcb_ben-1:0]                    lan_ben;

  assign req_off = req.adr[tcb_off-1:0];
  assign req_num = {{tcb_off{1'b0}}, 1'b1} << req.siz;
  assign req_wdt = req.wdt;

  // access runs past the last lane of the word
  assign req_crs = (req_off + req_num) > tcb_ben;
  assign req_rej = req_crs & ~allow_cross;

  // size decoded into a right aligned byte mask
  always_comb begin
    for (int unsigned k = 0; k < tcb_ben; k++) begin
      req_msk[k] = (k < req_num);
    end
  end

  // scatter request bytes onto the lanes
  // lane_of is a bijection so each lane gets exactly one byte
  always_comb begin
    lan_wdt = '0;
    lan_ben = '0;
    for (int unsigned k = 0; k < tcb_ben; k++) begin
      lan_wdt[lane_of(req.ndn, req_off, req_num, tcb_off'(k))] = req_wdt[k];
      lan_ben[lane_of(req.ndn, req_off, req_num, tcb_off'(k))] = req_msk[k];
    end
  end

  // aligned word access
  // a rejected access touches no lane
  assign mem_vld     = vld;
  assign mem_req.wen = req.wen;
  assign mem_req.adr = req.adr[tcb_adr-1:tcb_off];
  assign mem_req.ben = (vld && !req_rej) ? lan_ben : '0;
  assign mem_req.wdt = lan_wdt;

  //////////////////////////////////////////////////////////////////////
  // response stage
  //////////////////////////////////////////////////////////////////////

  logic [tcb_off-1:0]                    rsp_off;
  logic [tcb_off:0]                      rsp_num;
  tcb_ndn_t                              rsp_ndn;
  logic                                  rsp_rej;
  logic [tcb_ben-1:0][tcb_unt-1:0]       mem_lan;
  logic [tcb_ben-1:0][tcb_unt-1:0]       rsp_rdt;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      rsp_vld <= 1'b0;
    end else begin
      rsp_vld <= vld;
    end
  end

  // access shape kept for realignment of the read word
  always_ff @(posedge clk) begin
    if (vld) begin
      rsp_off <= req_off;
      rsp_num <= req_num;
      rsp_ndn <= req.ndn;
      rsp_rej <= req_rej;
    end
  end

  assign mem_lan = mem_rdt;

  // gather lanes back into request byte order with upper bytes zero
  always_comb begin
    rsp_rdt = '0;
    for (int unsigned k = 0; k < tcb_ben; k++) begin
      if (!rsp_rej && (k < rsp_num)) begin
        rsp_rdt[k] = mem_lan[lane_of(rsp_ndn, rsp_off, rsp_num, tcb_off'(k))];
      end
    end
  end

  assign rsp.rdt = rsp_rdt;
  assign rsp.sts = rsp_rej;

  // one pulse per rejected access in the cycle of its response
  assign err_evt = rsp_vld & rsp_rej;

  // manager never issues the reserved size
  a_siz_legal: assert property (@(posedge clk) disable iff (!rst_n)
    vld |-> (req.siz != 2'd3));

  // every accepted access enables exactly one lane per request byte
  a_ben_count: assert property (@(posedge clk) disable iff (!rst_n)
    (vld && !req_rej) |-> ($countones(mem_req.ben) == req_num));

endmodule

`default_nettype wire

// ==== hdl/tcb_pkg.sv ====
// shared sizes, encodings and bus structs, imported by every module of the memory subsystem
`default_nettype none

package tcb_pkg;

  //////////////////////////////////////////////////////////////////////
  // bus sizes
  //////////////////////////////////////////////////////////////////////

  // bits per byte lane
  localparam int unsigned tcb_unt = 8;
  // byte lanes per data word
  localparam int unsigned tcb_ben = 4;
  // byte offset bits inside a word
  localparam int unsigned tcb_off = 2;
  // byte address width, 256 words of memory
  localparam int unsigned tcb_adr = 10;
  // data width
  localparam int unsigned tcb_dat = 32;
  // register address width on the wishbone port
  localparam int unsigned wb_adr  = 2;

  // register offsets
  localparam logic [wb_adr-1:0] reg_ctrl    = wb_adr'(0);
  localparam logic [wb_adr-1:0] reg_err_cnt = wb_adr'(1);

  //////////////////////////////////////////////////////////////////////
  // encodings
  //////////////////////////////////////////////////////////////////////

  // endianness of a single request
  typedef enum logic {
    tcb_little = 1'b0,
    tcb_big    = 1'b1
  } tcb_ndn_t;

  // logarithmic transfer size, value 3 is illegal
  typedef enum logic [1:0] {
    tcb_siz_byte = 2'd0,
    tcb_siz_half = 2'd1,
    tcb_siz_word = 2'd2
  } tcb_siz_t;

  //////////////////////////////////////////////////////////////////////
  // bus structs
  //////////////////////////////////////////////////////////////////////

  // tcb request from the cpu side manager
  typedef struct packed {
    logic                 wen;  // write enable
    tcb_ndn_t             ndn;  // endianness
    tcb_siz_t             siz;  // log2 of byte count
    logic [tcb_adr-1:0]   adr;  // byte address
    logic [tcb_dat-1:0]   wdt;  // write data, right aligned
  } tcb_req_t;

  // tcb response
  typedef struct packed {
    logic [tcb_dat-1:0]   rdt;  // read data, right aligned
    logic                 sts;  // 1 means error
  } tcb_rsp_t;

  // aligned word access towards the memory
  typedef struct packed {
    logic                         wen;
    logic [tcb_adr-tcb_off-1:0]   adr;  // word address
    logic [tcb_ben-1:0]           ben;
    logic [tcb_dat-1:0]           wdt;
  } mem_req_t;

  // wishbone classic manager signals
  typedef struct packed {
    logic                 cyc;
    logic                 stb;
    logic                 we;
    logic [wb_adr-1:0]    adr;
    logic [tcb_dat-1:0]   dat_w;
  } wb_req_t;

  // wishbone classic subordinate signals
  typedef struct packed {
    logic                 ack;
    logic [tcb_dat-1:0]   dat_r;
  } wb_rsp_t;

endpackage

`default_nettype wire
